//--- compile.f
+incdir+common
common/afu_pkg.sv
design/ram.sv
write_buffer/write_data_control.sv
write_buffer/write_command_control.sv
design/afu_write_path.sv
verif/afu_write_path_tb.sv

//--- Makefile
TOP := afu_write_path_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module afu_write_path +incdir+common \
		common/afu_pkg.sv design/ram.sv write_buffer/write_data_control.sv \
		write_buffer/write_command_control.sv design/afu_write_path.sv

clean:
	rm -rf obj_dir sim.log

//--- verif/afu_write_path_tb.sv
`include "afu_cfg.svh"

module afu_write_path_tb
  import afu_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 50;
  // how long a blocked request is watched
  localparam int BLOCK_CYCLES   = 20;

  logic           clock;
  logic           rstn;
  logic           enabled_in;
  logic           write_req;
  write_request_t write_request;
  logic           write_ack;
  write_command_t write_command;
  response_t      response;
  buffer_read_t   buffer_read;
  buffer_data_t   buffer_data;
  logic           data_write_error;

  integer seed = 33057;
  int     error_count;
  int     timeout_count;
  int     next_tag;

  // reference copy of what each tag should hold
  logic [`HALF_LINE_BITS-1:0] model_half_0 [`BUFFER_DEPTH];
  logic [`HALF_LINE_BITS-1:0] model_half_1 [`BUFFER_DEPTH];

  // line currently offered by the client
  logic [`HALF_LINE_BITS-1:0] pending_half_0;
  logic [`HALF_LINE_BITS-1:0] pending_half_1;
  logic [63:0]                pending_address;

  afu_write_path afu_write_path_inst (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .write_req       (write_req),
    .write_request   (write_request),
    .write_ack       (write_ack),
    .write_command   (write_command),
    .response        (response),
    .buffer_read     (buffer_read),
    .buffer_data     (buffer_data),
    .data_write_error(data_write_error)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  //////////////////////////////////////////////////////////////////////
  // reference models and reporting
  //////////////////////////////////////////////////////////////////////

  // odd parity counted bit by bit
  function automatic logic tag_parity_model(input logic [7:0] tag);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (tag[i]) begin
        ones++;
      end
    end
    return (ones % 2) == 0;
  endfunction

  // one odd parity bit per 64-bit doubleword
  function automatic logic [`DW_COUNT-1:0] dw_parity_model(
    input logic [`HALF_LINE_BITS-1:0] data
  );
    logic [`DW_COUNT-1:0] par;
    int                   ones;
    for (int d = 0; d < `DW_COUNT; d++) begin
      ones = 0;
      for (int b = 0; b < 64; b++) begin
        if (data[d*64 + b]) begin
          ones++;
        end
      end
      par[d] = (ones % 2) == 0;
    end
    return par;
  endfunction

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("CHECK FAILED at time %0t: %s", $time, msg);
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timed out at time %0t while waiting for %s", $time, what);
  endtask

  task automatic random_half(output logic [`HALF_LINE_BITS-1:0] value);
    for (int i = 0; i < `HALF_LINE_BITS / 32; i++) begin
      value[i*32 +: 32] = $random(seed);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // client and host drivers
  //////////////////////////////////////////////////////////////////////

  // client raises req with a fresh random line
  task automatic start_request(input logic [63:0] address);
    random_half(pending_half_0);
    random_half(pending_half_1);
    pending_address = address;
    @(posedge clock);
    write_request.address     <= address;
    write_request.half_0.data <= pending_half_0;
    write_request.half_1.data <= pending_half_1;
    write_req                 <= 1'b1;
  endtask

  // command check and then the rest of the four-phase handshake
  task automatic finish_request();
    int n;
    n = 0;
    @(negedge clock);
    while (!write_command.valid && n < TIMEOUT_CYCLES) begin
      @(negedge clock);
      n++;
    end
    if (!write_command.valid) begin
      report_timeout("write_command valid");
    end else begin
      if (write_command.tag != next_tag[7:0]) begin
        report_mismatch($sformatf("command tag %0d, expected %0d",
                                  write_command.tag, next_tag));
      end
      if (write_command.tag_parity != tag_parity_model(next_tag[7:0])) begin
        report_mismatch($sformatf("wrong tag parity on tag %0d", next_tag));
      end
      if (write_command.address != pending_address) begin
        report_mismatch($sformatf("command address %h, expected %h",
                                  write_command.address, pending_address));
      end
      if (!write_ack) begin
        report_mismatch("write_ack not raised with write_command");
      end
      model_half_0[next_tag] = pending_half_0;
      model_half_1[next_tag] = pending_half_1;
      next_tag++;
      // ack holds while req is still up
      @(negedge clock);
      if (!write_ack) begin
        report_mismatch("write_ack fell while write_req was high");
      end
      if (write_command.valid) begin
        report_mismatch("write_command valid longer than one cycle");
      end
    end
    @(posedge clock);
    write_req <= 1'b0;
    n = 0;
    @(negedge clock);
    while (write_ack && n < TIMEOUT_CYCLES) begin
      @(negedge clock);
      n++;
    end
    if (write_ack) begin
      report_timeout("write_ack to fall");
    end
  endtask

  // host pull with the bus watched cycle by cycle around the fixed latency
  task automatic host_read(input int tag, input logic [5:0] address,
                           input bit bad_parity, input bit expect_data);
    logic [`HALF_LINE_BITS-1:0] expected;
    logic                       expect_error;
    expected = (address == 0) ? model_half_0[tag] : model_half_1[tag];
    @(posedge clock);
    buffer_read.read_valid      <= 1'b1;
    buffer_read.read_tag        <= tag[7:0];
    buffer_read.read_tag_parity <= tag_parity_model(tag[7:0]) ^ bad_parity;
    buffer_read.read_address    <= address;
    // dut samples the request on this edge
    @(posedge clock);
    buffer_read.read_valid <= 1'b0;
    for (int cyc = 0; cyc <= `READ_LATENCY + 2; cyc++) begin
      @(negedge clock);
      if (expect_data && cyc == `READ_LATENCY) begin
        if (buffer_data.read_data != expected) begin
          report_mismatch($sformatf("read data of tag %0d address %0d",
                                    tag, address));
        end
        if (buffer_data.read_parity != dw_parity_model(expected)) begin
          report_mismatch($sformatf("read parity %h of tag %0d, expected %h",
                                    buffer_data.read_parity, tag,
                                    dw_parity_model(expected)));
        end
      end else if (buffer_data != '1) begin
        report_mismatch($sformatf("buffer_data not all ones, %0d cycles after read",
                                  cyc));
      end
      expect_error = bad_parity && expect_data && (cyc == `READ_LATENCY + 1);
      if (data_write_error != expect_error) begin
        report_mismatch($sformatf("data_write_error %0b, expected %0b, cycle %0d",
                                  data_write_error, expect_error, cyc));
      end
    end
  endtask

  task automatic send_response(input int tag);
    @(posedge clock);
    response.valid <= 1'b1;
    response.tag   <= tag[7:0];
    @(posedge clock);
    response.valid <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic verify_reset_state();
    @(negedge clock);
    if (write_ack || write_command.valid || data_write_error) begin
      report_mismatch("control outputs not low after reset");
    end
    if (buffer_data != '1) begin
      report_mismatch("buffer_data not all ones after reset");
    end
  endtask

  // fills the outstanding window with tags 0 to 3
  task automatic issue_and_check_commands();
    for (int i = 0; i < `MAX_OUTSTANDING; i++) begin
      start_request(64'h0000_7f00_0000_0000 + 64'(i) * 128);
      finish_request();
    end
  endtask

  task automatic read_back_all_tags();
    for (int t = 0; t < `MAX_OUTSTANDING; t++) begin
      host_read(t, 6'd0, 1'b0, 1'b1);
      host_read(t, 6'(t + 1), 1'b0, 1'b1);
    end
    // top address bits also pick half 1
    host_read(2, 6'h3f, 1'b0, 1'b1);
  endtask

  task automatic tag_parity_error();
    host_read(2, 6'd0, 1'b1, 1'b1);
    host_read(3, 6'd5, 1'b1, 1'b1);
    // clean read right after raises no error
    host_read(1, 6'd0, 1'b0, 1'b1);
  endtask

  task automatic back_pressure_and_release();
    start_request(64'h0000_7f00_0000_4000);
    for (int n = 0; n < BLOCK_CYCLES; n++) begin
      @(negedge clock);
      if (write_ack || write_command.valid) begin
        report_mismatch("fifth request accepted with four tags in flight");
      end
    end
    // freeing tag 0 lets tag 4 through
    send_response(0);
    finish_request();
    host_read(4, 6'd0, 1'b0, 1'b1);
    host_read(4, 6'd1, 1'b0, 1'b1);
  endtask

  task automatic disabled_reads();
    @(posedge clock);
    enabled_in <= 1'b0;
    // enable lags one cycle inside the data control
    repeat (2) @(posedge clock);
    host_read(1, 6'd0, 1'b1, 1'b0);
    host_read(1, 6'd3, 1'b0, 1'b0);
    @(posedge clock);
    enabled_in <= 1'b1;
    repeat (2) @(posedge clock);
    host_read(1, 6'd0, 1'b0, 1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    error_count   = 0;
    timeout_count = 0;
    next_tag      = 0;
    rstn          = 1'b0;
    enabled_in    = 1'b0;
    write_req     = 1'b0;
    write_request = '0;
    response      = '0;
    buffer_read   = '0;
    repeat (5) @(posedge clock);
    rstn <= 1'b1;

    verify_reset_state();
    @(posedge clock);
    enabled_in <= 1'b1;
    repeat (2) @(posedge clock);

    issue_and_check_commands();
    read_back_all_tags();
    tag_parity_error();
    back_pressure_and_release();
    disabled_reads();

    // drain the tags still in flight
    for (int t = 1; t < next_tag; t++) begin
      send_response(t);
    end
    repeat (4) @(posedge clock);

    $display("errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- design/afu_write_path.sv
module afu_write_path
  import afu_pkg::*;
(
  input  logic           clock,
  input  logic           rstn,
  input  logic           enabled_in,
  // client side
  input  logic           write_req,
  input  write_request_t write_request,
  output logic           write_ack,
  // host side
  output write_command_t write_command,
  input  response_t      response,
  input  buffer_read_t   buffer_read,
  output buffer_data_t   buffer_data,
  output logic           data_write_error
);

  // line handoff between the two controls
  buffer_write_t buffer_write;

  write_command_control write_command_control_inst (
    .clock        (clock),
    .rstn         (rstn),
    .write_req    (write_req),
    .write_request(write_request),
    .write_ack    (write_ack),
    .buffer_write (buffer_write),
    .write_command(write_command),
    .response     (response)
  );

  write_data_control write_data_control_inst (
    .clock           (clock),
    .rstn            (rstn),
    .enabled_in      (enabled_in),
    .buffer_write    (buffer_write),
    .buffer_read     (buffer_read),
    .buffer_data     (buffer_data),
    .data_write_error(data_write_error)
  );

endmodule

//--- write_buffer/write_command_control.sv
`include "afu_cfg.svh"

module write_command_control
  import afu_pkg::*;
(
  input  logic           clock,
  input  logic           rstn,
  input  logic           write_req,
  input  write_request_t write_request,
  output logic           write_ack,
  output buffer_write_t  buffer_write,
  output write_command_t write_command,
  input  response_t      response
);

  command_state_t                         state;
  logic [`BUFFER_DEPTH-1:0]               busy_map;
  logic [$clog2(`MAX_OUTSTANDING+1)-1:0]  outstanding;
  logic [`TAG_BITS-1:0]                   next_tag;
  logic                                   can_accept;
  logic                                   accept;
  logic                                   write_valid;
  logic                                   command_valid;

  // line payload, captured on accept
  logic [`TAG_BITS-1:0]                   tag_q;
  logic [63:0]                            address_q;
  half_line_t                             half_0_q;
  half_line_t                             half_1_q;

  ////////////////////////////////////////////////////////////////////
  // intake FSM
  ////////////////////////////////////////////////////////////////////

  // back-pressure on busy tag or full window
  assign can_accept = !busy_map[next_tag] && (outstanding < `MAX_OUTSTANDING);
  assign accept     = (state == st_idle) && write_req && can_accept;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state         <= st_idle;
      write_valid   <= 1'b0;
      command_valid <= 1'b0;
      write_ack     <= 1'b0;
      next_tag      <= '0;
    end else begin
      write_valid   <= 1'b0;
      command_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            write_valid <= 1'b1;
            next_tag    <= next_tag + 1'b1;
            state       <= st_write;
          end
        end
        // data control latches and stores the line
        st_write: begin
          state <= st_issue;
        end
        st_issue: begin
          command_valid <= 1'b1;
          write_ack     <= 1'b1;
          state         <= st_release;
        end
        // wait for the client to drop req
        st_release: begin
          if (!write_req) begin
            write_ack <= 1'b0;
            state     <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      tag_q     <= next_tag;
      address_q <= write_request.address;
      half_0_q  <= write_request.half_0;
      half_1_q  <= write_request.half_1;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // busy map and outstanding count
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      busy_map    <= '0;
      outstanding <= '0;
    end else begin
      if (accept) begin
        busy_map[next_tag] <= 1'b1;
      end
      // response tag is busy, accept tag is free, never the same bit
      if (response.valid) begin
        busy_map[response.tag] <= 1'b0;
      end
      case ({accept, response.valid})
        2'b10:   outstanding <= outstanding + 1'b1;
        2'b01:   outstanding <= outstanding - 1'b1;
        default: outstanding <= outstanding;
      endcase
    end
  end

  assign buffer_write = '{valid: write_valid, tag: tag_q, half_0: half_0_q, half_1: half_1_q};

  assign write_command = '{
    valid:      command_valid,
    tag:        tag_q,
    tag_parity: odd_parity_byte(tag_q),
    address:    address_q
  };

  assert property (@(posedge clock) disable iff (!rstn)
    outstanding <= `MAX_OUTSTANDING);

  // host only completes tags it was given
  assert property (@(posedge clock) disable iff (!rstn)
    response.valid |-> busy_map[response.tag]);

endmodule

//--- write_buffer/write_data_control.sv
`include "afu_cfg.svh"

module write_data_control
  import afu_pkg::*;
(
  input  logic          clock,
  input  logic          rstn,
  input  logic          enabled_in,
  input  buffer_write_t buffer_write,
  input  buffer_read_t  buffer_read,
  output buffer_data_t  buffer_data,
  output logic          data_write_error
);

  logic                       enabled;
  logic                       write_valid_q;
  logic [`TAG_BITS-1:0]       write_tag_q;
  half_line_t                 write_half_0_q;
  half_line_t                 write_half_1_q;

  // read pipe, stage 1 is the captured request
  logic                       read_accept;
  logic                       read_valid_q;
  logic [`TAG_BITS-1:0]       read_tag_q;
  logic                       read_tag_parity_q;
  logic [5:0]                 read_address_q;

  // stage 2 lines up with the ram output
  half_line_t                 half_0_out;
  half_line_t                 half_1_out;
  logic                       read_valid_d2;
  logic                       read_half_1_d2;
  logic                       tag_mismatch_d2;

  // stage 3 selected half
  logic [`HALF_LINE_BITS-1:0] selected_data;
  logic                       tag_mismatch_d3;
  logic                       tag_mismatch_d4;

  ////////////////////////////////////////////////////////////////////
  // input latch and enable
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      enabled       <= 1'b0;
      write_valid_q <= 1'b0;
    end else begin
      // enable lags by one cycle
      enabled       <= enabled_in;
      write_valid_q <= buffer_write.valid;
    end
  end

  always_ff @(posedge clock) begin
    write_tag_q    <= buffer_write.tag;
    write_half_0_q <= buffer_write.half_0;
    write_half_1_q <= buffer_write.half_1;
  end

  ////////////////////////////////////////////////////////////////////
  // half-line buffers, indexed by tag
  ////////////////////////////////////////////////////////////////////

  ram #(
    .WIDTH($bits(half_line_t)),
    .DEPTH(`BUFFER_DEPTH)
  ) half_0_ram_inst (
    .clock   (clock),
    .we      (write_valid_q),
    .wr_addr (write_tag_q),
    .data_in (write_half_0_q),
    .rd_addr (read_tag_q),
    .data_out(half_0_out)
  );

  ram #(
    .WIDTH($bits(half_line_t)),
    .DEPTH(`BUFFER_DEPTH)
  ) half_1_ram_inst (
    .clock   (clock),
    .we      (write_valid_q),
    .wr_addr (write_tag_q),
    .data_in (write_half_1_q),
    .rd_addr (read_tag_q),
    .data_out(half_1_out)
  );

  ////////////////////////////////////////////////////////////////////
  // host read request
  ////////////////////////////////////////////////////////////////////

  // reads while disabled are dropped here
  assign read_accept = buffer_read.read_valid && enabled;

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_valid_q      <= 1'b0;
      read_tag_q        <= '0;
      read_tag_parity_q <= 1'b1;
      read_address_q    <= '0;
    end else begin
      read_valid_q <= read_accept;
      if (read_accept) begin
        read_tag_q        <= buffer_read.read_tag;
        read_tag_parity_q <= buffer_read.read_tag_parity;
        read_address_q    <= buffer_read.read_address;
      end
    end
  end

  // track the request alongside the ram read
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      read_valid_d2   <= 1'b0;
      read_half_1_d2  <= 1'b0;
      tag_mismatch_d2 <= 1'b0;
    end else begin
      read_valid_d2   <= read_valid_q;
      read_half_1_d2  <= |read_address_q;
      // recomputed vs captured tag parity
      tag_mismatch_d2 <= read_valid_q &&
                         (odd_parity_byte(read_tag_q) != read_tag_parity_q);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // half select and output stage
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      selected_data <= '1;
    end else if (!read_valid_d2) begin
      // idle bus reads as all ones
      selected_data <= '1;
    end else if (read_half_1_d2) begin
      selected_data <= half_1_out.data;
    end else begin
      selected_data <= half_0_out.data;
    end
  end

  // parity of all ones is all ones, so idle stays all ones
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      buffer_data <= '1;
    end else begin
      buffer_data.read_data   <= selected_data;
      buffer_data.read_parity <= odd_parity_dw(selected_data);
    end
  end

  ////////////////////////////////////////////////////////////////////
  // tag parity error
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_mismatch_d3  <= 1'b0;
      tag_mismatch_d4  <= 1'b0;
      data_write_error <= 1'b0;
    end else begin
      tag_mismatch_d3  <= tag_mismatch_d2;
      tag_mismatch_d4  <= tag_mismatch_d3;
      // one cycle behind the data
      data_write_error <= tag_mismatch_d4;
    end
  end

  // no accepted read means all ones on the bus READ_LATENCY edges on
  assert property (@(posedge clock) disable iff (!rstn)
    !read_accept |-> ##(`READ_LATENCY + 1) (buffer_data == '1));

  // an error always traces back to an accepted read
  assert property (@(posedge clock) disable iff (!rstn)
    data_write_error |-> $past(read_accept, `READ_LATENCY + 2));

endmodule

//--- design/ram.sv
module ram
  import afu_pkg::*;
#(
  parameter int WIDTH = 512,
  parameter int DEPTH = 256
) (
  input  logic                     clock,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  half_line_t               data_in,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  output half_line_t               data_out
);

  logic [WIDTH-1:0] mem [DEPTH];

  // storage width has to line up with the entry type
  if (WIDTH != $bits(half_line_t)) begin : g_width_check
    $error("ram WIDTH does not match half_line_t");
  end

  // write port
  always_ff @(posedge clock) begin
    if (we) begin
      mem[wr_addr] <= data_in;
    end
  end

  // registered read, same-address write gives old data
  always_ff @(posedge clock) begin
    data_out <= mem[rd_addr];
  end

endmodule

//--- common/afu_pkg.sv
`include "afu_cfg.svh"

package afu_pkg;

  ////////////////////////////////////////////////////////////////////////
  // data and bus structs
  ////////////////////////////////////////////////////////////////////////

  // one buffer entry
  typedef struct packed {
    logic [`HALF_LINE_BITS-1:0] data;
  } half_line_t;

  // client line write, held stable for the whole handshake
  typedef struct packed {
    logic [63:0] address;
    half_line_t  half_0;
    half_line_t  half_1;
  } write_request_t;

  // command control into data control
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
    half_line_t           half_0;
    half_line_t           half_1;
  } buffer_write_t;

  // write command toward the host
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
    logic                 tag_parity;
    logic [63:0]          address;
  } write_command_t;

  // host pull by tag, address 0 picks half 0
  typedef struct packed {
    logic                 read_valid;
    logic [`TAG_BITS-1:0] read_tag;
    logic                 read_tag_parity;
    logic [5:0]           read_address;
  } buffer_read_t;

  // read data back to the host
  typedef struct packed {
    logic [`HALF_LINE_BITS-1:0] read_data;
    logic [`DW_COUNT-1:0]       read_parity;
  } buffer_data_t;

  // host completion
  typedef struct packed {
    logic                 valid;
    logic [`TAG_BITS-1:0] tag;
  } response_t;

  // intake FSM states
  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_issue,
    st_release
  } command_state_t;

  ////////////////////////////////////////////////////////////////////////
  // parity helpers
  ////////////////////////////////////////////////////////////////////////

  // odd parity, set when the byte holds an even number of ones
  function automatic logic odd_parity_byte(input logic [7:0] data);
    return ~^data;
  endfunction

  // odd parity per doubleword, bit i covers doubleword i
  function automatic logic [`DW_COUNT-1:0] odd_parity_dw(
    input logic [`HALF_LINE_BITS-1:0] data
  );
    logic [`DW_COUNT-1:0] par;
    for (int i = 0; i < `DW_COUNT; i++) begin
      par[i] = ~^data[i*64 +: 64];
    end
    return par;
  endfunction

endpackage

//--- common/afu_cfg.svh
`ifndef AFU_CFG_SVH
`define AFU_CFG_SVH

////////////////////////////////////////////////////////////////////////
// write path sizing
////////////////////////////////////////////////////////////////////////

// command tag width, one buffer entry per tag
`define TAG_BITS 8
`define BUFFER_DEPTH 256

// half of a 128 byte cache line
`define HALF_LINE_BITS 512
// 64-bit doublewords per half line, one parity bit each
`define DW_COUNT 8

// host buffer read latency in cycles
`define READ_LATENCY 3
// tags allowed in flight
`define MAX_OUTSTANDING 4

`endif
